// File: rta.f
source/rta_pkg.sv
source/rta_mmio_regs.sv
source/rta_main_mem.sv
source/rta_stream_fifo.sv
source/rta_dma_reader.sv
source/rta_dma_writer.sv
source/rta_top.sv
verif/rta_tb.sv

// File: run_rta.sh
#!/bin/sh
# builds rta_tb with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

log=rta_sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module rta_tb -f rta.f --Mdir obj_rta -o rta_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_rta/rta_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST OK" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1

// File: source/rta_dma_reader.sv
// read engine, streams size words from src into the FIFO
// memory data arrives one cycle after rd_en, so at most one read is in flight
// a read is only issued when the FIFO has room for it and for the read in flight
`default_nettype none

module rta_dma_reader #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic                          go,
   input  wire rta_pkg::mem_addr_t            src,
   input  wire rta_pkg::count_t               size,
   input  wire logic [$clog2(FIFO_DEPTH):0]   fifo_count,
   input  wire rta_pkg::word_t                rd_data,
   output logic                               rd_en,
   output rta_pkg::mem_addr_t                 rd_addr,
   output logic                               push,
   output rta_pkg::word_t                     push_data
);

   localparam int cnt_w = $clog2(FIFO_DEPTH) + 1;

   rta_pkg::count_t    left;
   rta_pkg::mem_addr_t addr_q;
   logic               in_flight;
   logic [cnt_w-1:0]   used;

   // entries already stored plus the word that lands this cycle
   assign used  = fifo_count + cnt_w'(in_flight);
   assign rd_en = left != '0 && used < FIFO_DEPTH;

   assign rd_addr = addr_q;

   // the word read last cycle is on rd_data now and goes straight into the FIFO
   assign push      = in_flight;
   assign push_data = rd_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         left      <= '0;
         addr_q    <= '0;
         in_flight <= 1'b0;
      end else begin
         in_flight <= rd_en;
         // go only comes while idle, left is zero then and no read is pending
         if (go) begin
            left   <= size;
            addr_q <= src;
         end else if (rd_en) begin
            left   <= left - 1'b1;
            addr_q <= addr_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/rta_dma_writer.sv
// write engine, drains the FIFO into the destination region
// each popped word is written in the cycle of the pop
// done rises the cycle after the last write and stays up until the next go
// overlapping source and destination regions give undefined results
`default_nettype none

module rta_dma_writer (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire logic                go,
   input  wire rta_pkg::mem_addr_t  dst,
   input  wire rta_pkg::count_t     size,
   input  wire logic                empty,
   input  wire rta_pkg::word_t      pop_data,
   output logic                     pop,
   output logic                     wr_en,
   output rta_pkg::mem_addr_t       wr_addr,
   output rta_pkg::word_t           wr_data,
   output logic                     done
);

   // words still to be retired, and where the next one goes
   rta_pkg::count_t    left;
   rta_pkg::mem_addr_t addr_q;

   // the FIFO only ever holds words of the current copy
   assign pop     = !empty && left != '0;
   assign wr_en   = pop;
   assign wr_addr = addr_q;
   assign wr_data = pop_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         left   <= '0;
         addr_q <= '0;
         done   <= 1'b0;
      end else begin
         if (go) begin
            left   <= size;
            addr_q <= dst;
            // an empty copy finishes at once
            done   <= size == '0;
         end else if (pop) begin
            left   <= left - 1'b1;
            addr_q <= addr_q + 1'b1;
            if (left == rta_pkg::count_t'(1)) begin
               done <= 1'b1;
            end
         end
      end
   end

   // once done is up no word of the old copy may still be written
   a_no_write_done: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> !done);

endmodule

`default_nettype wire

// File: source/rta_main_mem.sv
// main memory with one registered read port and one write port
// the DMA engines and the host share both ports and never use one at once
// a read and a write to the same word in one cycle return the old word
// rd_data holds its value until the next read
`default_nettype none

module rta_main_mem #(
   parameter int MEM_DEPTH = 1024
) (
   input  wire logic                clk,
   input  wire logic                dma_re,
   input  wire rta_pkg::mem_addr_t  dma_raddr,
   input  wire logic                dma_we,
   input  wire rta_pkg::mem_addr_t  dma_waddr,
   input  wire rta_pkg::word_t      dma_wdata,
   input  wire logic                host_re,
   input  wire logic                host_we,
   input  wire rta_pkg::mem_addr_t  host_addr,
   input  wire rta_pkg::word_t      host_wdata,
   output rta_pkg::word_t           rd_data
);

   rta_pkg::word_t     mem [MEM_DEPTH];
   logic               re;
   logic               we;
   rta_pkg::mem_addr_t raddr;
   rta_pkg::mem_addr_t waddr;
   rta_pkg::word_t     wdata;

   // the requests are exclusive, so an OR of the gated fields selects the owner
   assign re    = dma_re | host_re;
   assign raddr = (dma_re ? dma_raddr : '0) | (host_re ? host_addr : '0);
   assign we    = dma_we | host_we;
   assign waddr = (dma_we ? dma_waddr : '0) | (host_we ? host_addr : '0);
   assign wdata = (dma_we ? dma_wdata : '0) | (host_we ? host_wdata : '0);

   always_ff @(posedge clk) begin
      if (re) begin
         rd_data <= mem[raddr];
      end
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // the register map keeps the host off the ports while a copy runs
   a_rd_owner: assert property (@(posedge clk) !(dma_re && host_re));
   a_wr_owner: assert property (@(posedge clk) !(dma_we && host_we));

endmodule

`default_nettype wire

// File: source/rta_mmio_regs.sv
// AXI4-Lite slave holding the copy registers and the indirect memory window
// write strobes are ignored, every register is written as a full word
// one write and one read may be outstanding, the next waits for its response
// MEM_DATA is blocked while a copy runs: writes are dropped, reads return 0
`default_nettype none

module rta_mmio_regs (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire rta_pkg::axi_addr_t    s_axi_awaddr,
   input  wire logic                  s_axi_awvalid,
   output logic                       s_axi_awready,
   input  wire rta_pkg::word_t        s_axi_wdata,
   input  wire logic [3:0]            s_axi_wstrb,
   input  wire logic                  s_axi_wvalid,
   output logic                       s_axi_wready,
   output logic [1:0]                 s_axi_bresp,
   output logic                       s_axi_bvalid,
   input  wire logic                  s_axi_bready,
   input  wire rta_pkg::axi_addr_t    s_axi_araddr,
   input  wire logic                  s_axi_arvalid,
   output logic                       s_axi_arready,
   output rta_pkg::word_t             s_axi_rdata,
   output logic [1:0]                 s_axi_rresp,
   output logic                       s_axi_rvalid,
   input  wire logic                  s_axi_rready,
   input  wire logic                  done,
   input  wire rta_pkg::word_t        host_rd_data,
   output rta_pkg::mem_addr_t         src,
   output rta_pkg::mem_addr_t         dst,
   output rta_pkg::count_t            size,
   output logic                       go,
   output logic                       host_we,
   output logic                       host_re,
   output rta_pkg::mem_addr_t         host_addr,
   output rta_pkg::word_t             host_wr_data
);

   logic               busy;
   logic               aw_hs;
   logic               ar_hs;
   logic               rd_stage;
   logic               rd_mem_ok;
   rta_pkg::axi_addr_t rd_off;
   rta_pkg::word_t     rd_word;
   rta_pkg::mem_addr_t mem_addr;

   function automatic logic is_mapped(input rta_pkg::axi_addr_t a);
      return a inside {rta_pkg::reg_src, rta_pkg::reg_dst, rta_pkg::reg_size,
                       rta_pkg::reg_ctrl, rta_pkg::reg_status,
                       rta_pkg::reg_mem_addr, rta_pkg::reg_mem_data};
   endfunction

   // ==================================================
   // write channel
   // ==================================================

   // address and data are taken together, and only when no response is waiting
   assign s_axi_awready = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
   assign s_axi_wready  = s_axi_awready;
   assign aw_hs         = s_axi_awvalid && s_axi_awready;

   // the go cycle counts as busy too, the engines load their counters there
   assign host_we      = aw_hs && s_axi_awaddr == rta_pkg::reg_mem_data && !(busy || go);
   assign host_wr_data = s_axi_wdata;
   assign host_addr    = mem_addr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         src          <= '0;
         dst          <= '0;
         size         <= '0;
         mem_addr     <= '0;
         go           <= 1'b0;
         busy         <= 1'b0;
         s_axi_bvalid <= 1'b0;
      end else begin
         // a go request while a copy runs is acknowledged and dropped
         go <= aw_hs && s_axi_awaddr == rta_pkg::reg_ctrl && s_axi_wdata[0] && !busy && !go;
         if (go) begin
            busy <= 1'b1;
         end else if (done) begin
            busy <= 1'b0;
         end
         if (aw_hs) begin
            s_axi_bvalid <= 1'b1;
            case (s_axi_awaddr)
               rta_pkg::reg_src:      src      <= rta_pkg::mem_addr_t'(s_axi_wdata);
               rta_pkg::reg_dst:      dst      <= rta_pkg::mem_addr_t'(s_axi_wdata);
               rta_pkg::reg_size:     size     <= rta_pkg::count_t'(s_axi_wdata);
               rta_pkg::reg_mem_addr: mem_addr <= rta_pkg::mem_addr_t'(s_axi_wdata);
               default: ;
            endcase
         end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
         end
      end
   end

   // ==================================================
   // read channel
   // ==================================================

   // the memory read starts in the AR handshake cycle, data comes back one cycle later
   assign s_axi_arready = s_axi_arvalid && !rd_stage && !s_axi_rvalid;
   assign ar_hs         = s_axi_arvalid && s_axi_arready;
   assign host_re       = ar_hs && s_axi_araddr == rta_pkg::reg_mem_data && !(busy || go);

   always_comb begin
      case (rd_off)
         rta_pkg::reg_src:      rd_word = 32'(src);
         rta_pkg::reg_dst:      rd_word = 32'(dst);
         rta_pkg::reg_size:     rd_word = 32'(size);
         rta_pkg::reg_status:   rd_word = {30'b0, busy, done};
         rta_pkg::reg_mem_addr: rd_word = 32'(mem_addr);
         rta_pkg::reg_mem_data: rd_word = rd_mem_ok ? host_rd_data : '0;
         // CTRL is write only
         default:               rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_stage     <= 1'b0;
         s_axi_rvalid <= 1'b0;
      end else begin
         rd_stage <= ar_hs;
         if (rd_stage) begin
            s_axi_rvalid <= 1'b1;
         end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
         end
      end
   end

   // response payloads, only sampled together with their valid
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         s_axi_bresp <= is_mapped(s_axi_awaddr) ? rta_pkg::resp_okay : rta_pkg::resp_slverr;
      end
      if (ar_hs) begin
         rd_off    <= s_axi_araddr;
         rd_mem_ok <= !(busy || go);
      end
      // rdata is captured once, so it holds while rready stalls
      if (rd_stage) begin
         s_axi_rdata <= rd_word;
         s_axi_rresp <= is_mapped(rd_off) ? rta_pkg::resp_okay : rta_pkg::resp_slverr;
      end
   end

   // ==================================================
   // assertions
   // ==================================================
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

   // a second go would restart the engines in the middle of a copy
   a_go_idle: assert property (@(posedge clk) disable iff (!arst_n)
      go |-> !busy);

   a_wr_known: assert property (@(posedge clk) disable iff (!arst_n)
      aw_hs |-> !$isunknown({s_axi_awaddr, s_axi_wdata, s_axi_wstrb}));

endmodule

`default_nettype wire

// File: source/rta_pkg.sv
// shared types and constants of the copy accelerator
// main memory is word addressed with 1024 words of 32 bits
// the AXI4-Lite address is 8 bits wide, only word aligned offsets are mapped
`default_nettype none

package rta_pkg;

   // ==================================================
   // data and address types
   // ==================================================

   // one memory word, also the AXI4-Lite data width
   typedef logic [31:0] word_t;

   // word address into main memory
   typedef logic [9:0] mem_addr_t;

   // one bit wider than an address, so a copy of the full memory fits
   typedef logic [10:0] count_t;

   // byte offset seen on the AXI4-Lite address channels
   typedef logic [7:0] axi_addr_t;

   // ==================================================
   // register map, byte offsets
   // ==================================================
   localparam axi_addr_t reg_src      = 8'h00;
   localparam axi_addr_t reg_dst      = 8'h04;
   localparam axi_addr_t reg_size     = 8'h08;
   // bit 0 starts a copy, reads as zero
   localparam axi_addr_t reg_ctrl     = 8'h0C;
   // bit 0 done, bit 1 busy
   localparam axi_addr_t reg_status   = 8'h10;
   localparam axi_addr_t reg_mem_addr = 8'h14;
   localparam axi_addr_t reg_mem_data = 8'h18;

   // AXI response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: source/rta_stream_fifo.sv
// synchronous FIFO between the read and the write engine
// DEPTH must be a power of two of at least 4
// pop_data shows the oldest entry while empty is low, so a pop needs no wait cycle
// the producer must respect count, a push into a full FIFO is not allowed
`default_nettype none

module rta_stream_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 8
) (
   input  wire logic                       clk,
   input  wire logic                       arst_n,
   input  wire logic                       push,
   input  wire payload_t                   push_data,
   input  wire logic                       pop,
   output payload_t                        pop_data,
   output logic                            empty,
   output logic [$clog2(DEPTH):0]          count
);

   localparam int ptr_w = $clog2(DEPTH);

   payload_t           buffer [DEPTH];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;

   assign empty    = count == '0;
   assign pop_data = buffer[rd_ptr];

   // pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         buffer[wr_ptr] <= push_data;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> count != DEPTH);
   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> !empty);

endmodule

`default_nettype wire

// File: source/rta_top.sv
// copy accelerator top, AXI4-Lite slave in front of main memory and two DMA engines
// FIFO_DEPTH must be a power of two of at least 4
// MEM_DEPTH must not exceed the 1024 words the address type can reach
`default_nettype none

module rta_top #(
   parameter int MEM_DEPTH  = 1024,
   parameter int FIFO_DEPTH = 8
) (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire rta_pkg::axi_addr_t  s_axi_awaddr,
   input  wire logic                s_axi_awvalid,
   output logic                     s_axi_awready,
   input  wire rta_pkg::word_t      s_axi_wdata,
   input  wire logic [3:0]          s_axi_wstrb,
   input  wire logic                s_axi_wvalid,
   output logic                     s_axi_wready,
   output logic [1:0]               s_axi_bresp,
   output logic                     s_axi_bvalid,
   input  wire logic                s_axi_bready,
   input  wire rta_pkg::axi_addr_t  s_axi_araddr,
   input  wire logic                s_axi_arvalid,
   output logic                     s_axi_arready,
   output rta_pkg::word_t           s_axi_rdata,
   output logic [1:0]               s_axi_rresp,
   output logic                     s_axi_rvalid,
   input  wire logic                s_axi_rready
);

   rta_pkg::mem_addr_t              src, dst, host_addr, rd_addr, wr_addr;
   rta_pkg::count_t                 size;
   rta_pkg::word_t                  host_wr_data, mem_rd_data, push_data, pop_data, wr_data;
   logic                            go, done, host_we, host_re;
   logic                            rd_en, wr_en, push, pop, empty;
   logic [$clog2(FIFO_DEPTH):0]     fifo_count;

   rta_mmio_regs u_regs (
      .clk, .arst_n,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
      .done, .host_rd_data(mem_rd_data), .src, .dst, .size, .go,
      .host_we, .host_re, .host_addr, .host_wr_data
   );

   rta_main_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
      .clk, .dma_re(rd_en), .dma_raddr(rd_addr),
      .dma_we(wr_en), .dma_waddr(wr_addr), .dma_wdata(wr_data),
      .host_re, .host_we, .host_addr, .host_wdata(host_wr_data),
      .rd_data(mem_rd_data)
   );

   rta_dma_reader #(.FIFO_DEPTH(FIFO_DEPTH)) u_reader (
      .clk, .arst_n, .go, .src, .size, .fifo_count, .rd_data(mem_rd_data),
      .rd_en, .rd_addr, .push, .push_data
   );

   rta_stream_fifo #(.payload_t(rta_pkg::word_t), .DEPTH(FIFO_DEPTH)) u_fifo (
      .clk, .arst_n, .push, .push_data, .pop, .pop_data, .empty, .count(fifo_count)
   );

   rta_dma_writer u_writer (
      .clk, .arst_n, .go, .dst, .size, .empty, .pop_data,
      .pop, .wr_en, .wr_addr, .wr_data, .done
   );

endmodule

`default_nettype wire

// File: verif/rta_tb.sv
// testbench for the copy accelerator that drives rta_top through its AXI4-Lite port
// memory contents are predicted by a model array that only covers words the test wrote
// only one AXI transaction is outstanding at a time
// bready and rready are delayed at random
// value checks sit in concurrent assertions that compare against expected registers
`default_nettype none

module rta_tb;

   // the copy lengths that the tests can reach size the watchdog
   localparam int copy_words     = 64 + 128;
   localparam int watchdog_limit = 200 * copy_words + 5000;

   logic               clk = 1'b0;
   logic               arst_n;
   logic [7:0]         s_axi_awaddr;
   logic               s_axi_awvalid;
   logic               s_axi_awready;
   logic [31:0]        s_axi_wdata;
   logic [3:0]         s_axi_wstrb;
   logic               s_axi_wvalid;
   logic               s_axi_wready;
   logic [1:0]         s_axi_bresp;
   logic               s_axi_bvalid;
   logic               s_axi_bready;
   logic [7:0]         s_axi_araddr;
   logic               s_axi_arvalid;
   logic               s_axi_arready;
   logic [31:0]        s_axi_rdata;
   logic [1:0]         s_axi_rresp;
   logic               s_axi_rvalid;
   logic               s_axi_rready;

   // expected response values are set when a request is launched
   logic [1:0]         exp_bresp;
   logic [1:0]         exp_rresp;
   logic [31:0]        exp_rdata;
   logic               chk_rdata;
   logic [31:0]        model [1024];
   int                 errors = 0;
   int                 aw_cnt, b_cnt, ar_cnt, r_cnt;
   int                 addrs [16];

   rta_top #(.MEM_DEPTH(1024), .FIFO_DEPTH(8)) dut (.*);

   always #10 clk = ~clk;

   // handshake counters expose a response without a request as a duplicate
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_cnt <= 0;
         b_cnt  <= 0;
         ar_cnt <= 0;
         r_cnt  <= 0;
      end else begin
         if (s_axi_awvalid && s_axi_awready) aw_cnt <= aw_cnt + 1;
         if (s_axi_bvalid && s_axi_bready) b_cnt <= b_cnt + 1;
         if (s_axi_arvalid && s_axi_arready) ar_cnt <= ar_cnt + 1;
         if (s_axi_rvalid && s_axi_rready) r_cnt <= r_cnt + 1;
      end
   end

   // every failed check lands here and counts toward the summary
   function automatic void flag_error(input string msg);
      errors++;
      $display("** Error @%0t: %s", $time, msg);
   endfunction

   // ==================================================
   // protocol and value checks
   // ==================================================
   a_b_stable: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
      else flag_error("bvalid or bresp moved during a stall");
   a_r_stable: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable({s_axi_rdata, s_axi_rresp}))
      else flag_error("rvalid or read payload moved during a stall");
   a_w_ready: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_awready || s_axi_wready |->
         s_axi_awready && s_axi_wready && s_axi_awvalid && s_axi_wvalid)
      else flag_error("awready and wready were not raised together for a valid write");
   a_bresp: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_bvalid && s_axi_bready |-> s_axi_bresp == exp_bresp)
      else flag_error($sformatf("bresp %0d, expected %0d", s_axi_bresp, exp_bresp));
   a_rresp: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_rvalid && s_axi_rready |-> s_axi_rresp == exp_rresp)
      else flag_error($sformatf("rresp %0d, expected %0d", s_axi_rresp, exp_rresp));
   a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_rvalid && s_axi_rready && chk_rdata |-> s_axi_rdata == exp_rdata)
      else flag_error($sformatf("rdata %h, expected %h", s_axi_rdata, exp_rdata));
   a_b_once: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_bvalid && s_axi_bready |-> b_cnt < aw_cnt)
      else flag_error("write response without a pending write");
   a_r_once: assert property (@(posedge clk) disable iff (!arst_n)
      s_axi_rvalid && s_axi_rready |-> r_cnt < ar_cnt)
      else flag_error("read response without a pending read");

   // ==================================================
   // AXI4-Lite transactions
   // ==================================================
   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
      int gap;
      gap = $urandom_range(0, 3);
      @(posedge clk);
      s_axi_awaddr  <= addr;
      s_axi_awvalid <= 1'b1;
      s_axi_wdata   <= data;
      s_axi_wvalid  <= 1'b1;
      s_axi_wstrb   <= 4'hF;
      exp_bresp     <= resp;
      // awready is combinational, so it is looked at between edges
      do @(negedge clk); while (!s_axi_awready);
      @(posedge clk);
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid  <= 1'b0;
      repeat (gap) @(posedge clk);
      s_axi_bready <= 1'b1;
      do @(negedge clk); while (!s_axi_bvalid);
      @(posedge clk);
      s_axi_bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp, input logic chk,
                           input logic [1:0] resp, output logic [31:0] data);
      int gap;
      gap = $urandom_range(0, 3);
      @(posedge clk);
      s_axi_araddr  <= addr;
      s_axi_arvalid <= 1'b1;
      exp_rdata     <= exp;
      chk_rdata     <= chk;
      exp_rresp     <= resp;
      do @(negedge clk); while (!s_axi_arready);
      @(posedge clk);
      s_axi_arvalid <= 1'b0;
      repeat (gap) @(posedge clk);
      s_axi_rready <= 1'b1;
      do @(negedge clk); while (!s_axi_rvalid);
      data = s_axi_rdata;
      @(posedge clk);
      s_axi_rready <= 1'b0;
   endtask

   task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] d;
      axi_read(addr, exp, 1'b1, rta_pkg::resp_okay, d);
   endtask

   // indirect memory access that the model follows on every write
   task automatic mem_write(input int addr, input logic [31:0] data);
      axi_write(rta_pkg::reg_mem_addr, 32'(addr), rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_mem_data, data, rta_pkg::resp_okay);
      model[addr] = data;
   endtask

   task automatic mem_check(input int addr);
      axi_write(rta_pkg::reg_mem_addr, 32'(addr), rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_mem_data, model[addr]);
   endtask

   task automatic start_copy(input int src, input int dst, input int len);
      axi_write(rta_pkg::reg_src, 32'(src), rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_dst, 32'(dst), rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_size, 32'(len), rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_ctrl, 32'h1, rta_pkg::resp_okay);
      for (int i = 0; i < len; i++) model[dst + i] = model[src + i];
   endtask

   // polls STATUS until done, then checks done set and busy clear
   task automatic wait_done();
      logic [31:0] st;
      do axi_read(rta_pkg::reg_status, 32'h0, 1'b0, rta_pkg::resp_okay, st); while (!st[0]);
      reg_check(rta_pkg::reg_status, 32'h1);
   endtask

   // ==================================================
   // watchdog
   // ==================================================
   initial begin
      repeat (watchdog_limit) @(posedge clk);
      $display("timeout: the run did not finish within %0d clock cycles", watchdog_limit);
      $display("TEST FAILED");
      $finish;
   end

   // ==================================================
   // test sequence
   // ==================================================
   initial begin
      logic [31:0] v;
      logic [31:0] d;
      int          len, src, dst;
      arst_n        = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      exp_bresp     = rta_pkg::resp_okay;
      exp_rresp     = rta_pkg::resp_okay;
      exp_rdata     = '0;
      chk_rdata     = 1'b0;
      v = $urandom(32'h7476);
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // registers read 0 after reset, then return what was written
      reg_check(rta_pkg::reg_src, 32'h0);
      reg_check(rta_pkg::reg_dst, 32'h0);
      reg_check(rta_pkg::reg_size, 32'h0);
      reg_check(rta_pkg::reg_mem_addr, 32'h0);
      reg_check(rta_pkg::reg_status, 32'h0);
      reg_check(rta_pkg::reg_ctrl, 32'h0);
      v = $urandom_range(0, 1023);
      axi_write(rta_pkg::reg_src, v, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_src, v);
      v = $urandom_range(0, 1023);
      axi_write(rta_pkg::reg_dst, v, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_dst, v);
      v = $urandom_range(0, 2047);
      axi_write(rta_pkg::reg_size, v, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_size, v);
      v = $urandom_range(0, 1023);
      axi_write(rta_pkg::reg_mem_addr, v, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_mem_addr, v);

      // random words go through the indirect window and are checked after all writes
      foreach (addrs[i]) begin
         addrs[i] = $urandom_range(0, 1023);
         mem_write(addrs[i], $urandom);
      end
      foreach (addrs[i]) mem_check(addrs[i]);

      // an empty copy while done is still low completes and leaves memory alone
      for (int i = 0; i < 4; i++) mem_write(12'h3F0 + i, $urandom);
      start_copy(0, 12'h3F0, 0);
      wait_done();
      for (int i = 0; i < 4; i++) mem_check(12'h3F0 + i);

      // random copy from the lower half into the upper half
      len = $urandom_range(1, 64);
      src = $urandom_range(0, 511 - len);
      dst = $urandom_range(512, 1023 - len);
      for (int i = 0; i < len; i++) begin
         mem_write(src + i, $urandom);
         mem_write(dst + i, $urandom);
      end
      start_copy(src, dst, len);
      wait_done();
      for (int i = 0; i < len; i++) begin
         mem_check(src + i);
         mem_check(dst + i);
      end

      // a second go during the copy would land in the 0x200 region
      for (int i = 0; i < 128; i++) begin
         mem_write(12'h100 + i, $urandom);
         mem_write(12'h200 + i, $urandom);
      end
      start_copy(12'h100, 12'h300, 128);
      axi_write(rta_pkg::reg_dst, 32'h200, rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_ctrl, 32'h1, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_status, 32'h2);
      axi_write(rta_pkg::reg_mem_addr, 32'h200, rta_pkg::resp_okay);
      axi_write(rta_pkg::reg_mem_data, $urandom, rta_pkg::resp_okay);
      reg_check(rta_pkg::reg_mem_data, 32'h0);
      wait_done();
      for (int i = 0; i < 128; i++) begin
         mem_check(12'h100 + i);
         mem_check(12'h200 + i);
         mem_check(12'h300 + i);
      end

      // unmapped offsets answer with SLVERR
      axi_write(8'h1C, $urandom, rta_pkg::resp_slverr);
      axi_write(8'h80, $urandom, rta_pkg::resp_slverr);
      axi_read(8'h1C, 32'h0, 1'b0, rta_pkg::resp_slverr, d);
      axi_read(8'h02, 32'h0, 1'b0, rta_pkg::resp_slverr, d);
      reg_check(rta_pkg::reg_dst, 32'h200);

      @(posedge clk);
      @(posedge clk);
      if (aw_cnt != b_cnt || ar_cnt != r_cnt) begin
         errors++;
         $display("response count mismatch: %0d writes got %0d responses, %0d reads got %0d",
                  aw_cnt, b_cnt, ar_cnt, r_cnt);
      end
      $display("summary: %0d errors, %0d writes, %0d reads", errors, aw_cnt, ar_cnt);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
